// ==== apbI2c.f ====
hdl/apbI2cRegPkg.sv
hdl/i2cBusPkg.sv
hdl/wordFifo.sv
hdl/apbRegs.sv
hdl/i2cEngine.sv
hdl/apbI2c.sv
dv/apbI2c_chk.sv
dv/apbI2cTb.sv

// ==== dv/apbI2cTb.sv ====
////////////////////
// Bridge testbench with an I2C slave model on a wired-AND bus
// Slave answers only 7-bit addresses, no clock stretching
////////////////////
`timescale 1ns/100ps

module apbI2cTb;

	localparam int txDepth = 8;
	localparam int rxDepth = 8;

	logic PCLK;
	logic PRESETn;
	logic PSEL;
	logic PENABLE;
	logic PWRITE;
	logic [apbI2cRegPkg::apbDataWidth-1:0] PADDR;
	logic [apbI2cRegPkg::apbDataWidth-1:0] PWDATA;
	logic [apbI2cRegPkg::apbDataWidth-1:0] PRDATA;
	logic PREADY;
	logic PSLVERR;
	logic sclOe;
	logic sdaOe;
	logic intTx;
	logic intRx;
	wire sclLine;
	wire sdaLine;

	// Slave model state
	logic [6:0] slaveAddr;
	logic slaveDrive;
	logic [7:0] shiftIn;
	logic [7:0] sendByte;
	logic inAddr;
	logic readDir;
	logic active;
	logic matched;
	int bitPos;
	int startCount;
	int stopCount;
	logic [i2cBusPkg::rxWordWidth-1:0] slaveData[$];
	logic [i2cBusPkg::rxWordWidth-1:0] busBytes[$];

	// Reference model queues and run parameters
	logic [i2cBusPkg::rxWordWidth-1:0] expBus[$];
	logic [i2cBusPkg::rxWordWidth-1:0] expRx[$];
	logic [7:0] divSel;
	logic [apbI2cRegPkg::regWidth-1:0] toLimit;
	int nData;
	int nRead;
	int busCycles;
	longint limitNs;

	// Open-drain bus, low wins
	assign sclLine = !sclOe;
	assign sdaLine = !(sdaOe | slaveDrive);

	apbI2c #(
		.txDepth(txDepth),
		.rxDepth(rxDepth)
	) apbI2c_inst (
		.PCLK(PCLK), .PRESETn(PRESETn), .PSEL(PSEL), .PENABLE(PENABLE),
		.PWRITE(PWRITE), .PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA),
		.PREADY(PREADY), .PSLVERR(PSLVERR), .sclOe(sclOe), .sdaOe(sdaOe),
		.sdaIn(sdaLine), .intTx(intTx), .intRx(intRx)
	);

	initial
	begin
		PCLK = 1'b0;
	end
	always #2 PCLK = ~PCLK;

	////////////////////
	// I2C slave model
	////////////////////
	initial
	begin
		slaveDrive = 1'b0;
		active = 1'b0;
		inAddr = 1'b0;
		readDir = 1'b0;
		matched = 1'b0;
		bitPos = 0;
		startCount = 0;
		stopCount = 0;
		shiftIn = '0;
		sendByte = '0;
	end

	// START is SDA falling with SCL high, STOP is SDA rising with SCL high
	always @(negedge sdaLine)
		if (PRESETn && sclLine)
		begin
			startCount++;
			bitPos = 0;
			inAddr = 1'b1;
			readDir = 1'b0;
			active = 1'b1;
		end
	always @(posedge sdaLine)
		if (PRESETn && sclLine)
		begin
			stopCount++;
			active = 1'b0;
		end

	always @(posedge sclLine)
	begin : sampleBit
		logic [7:0] full;
		if (active)
		begin
			full = {shiftIn[6:0], sdaLine};
			if (bitPos < 8)
			begin
				shiftIn = full;
				if (bitPos == 7 && inAddr)
				begin
					busBytes.push_back(full);
					matched = full[7:1] == slaveAddr;
					readDir = full[0];
				end
				else if (bitPos == 7 && !readDir)
					busBytes.push_back(full);
			end
			else
			begin
				// Unmatched address or master NACK ends our part
				if (!matched || (readDir && !inAddr && sdaLine))
					active = 1'b0;
				inAddr = 1'b0;
			end
			bitPos = (bitPos == 8) ? 0 : bitPos + 1;
		end
	end

	// SDA only changes while SCL is low
	always @(negedge sclLine)
	begin
		if (!active)
			slaveDrive = 1'b0;
		else if (bitPos == 8)
			slaveDrive = (inAddr || !readDir) && matched;
		else if (readDir && !inAddr)
		begin
			if (bitPos == 0)
				sendByte = (slaveData.size() > 0) ? slaveData.pop_front() : 8'hff;
			slaveDrive = !sendByte[7 - bitPos];
		end
		else
			slaveDrive = 1'b0;
	end

	////////////////////
	// Checks and APB access
	////////////////////
	task automatic failNow(input string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		$display("RESULT: FAIL");
		$fatal(1, "stopping on first mismatch");
	endtask

	task automatic checkRegWord(input logic [apbI2cRegPkg::regWidth-1:0] got,
		input logic [apbI2cRegPkg::regWidth-1:0] exp, input string what);
		if (got !== exp)
			failNow($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic checkBusByte(input logic [i2cBusPkg::rxWordWidth-1:0] got,
		input logic [i2cBusPkg::rxWordWidth-1:0] exp, input string what);
		if (got !== exp)
			failNow($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic checkStatus(input logic [apbI2cRegPkg::apbDataWidth-1:0] got,
		input logic [apbI2cRegPkg::apbDataWidth-1:0] exp);
		if (got !== exp)
			failNow($sformatf("status got %h expected %h", got, exp));
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp)
			failNow($sformatf("%s got %b expected %b", what, got, exp));
	endtask

	task automatic apbAccess(input logic write, input logic [31:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge PCLK);
		PSEL <= 1'b1;
		PENABLE <= 1'b0;
		PWRITE <= write;
		PADDR <= addr;
		PWDATA <= wdata;
		@(posedge PCLK);
		PENABLE <= 1'b1;
		@(negedge PCLK);
		if (!PREADY)
			failNow("PREADY low in the access phase");
		rdata = PRDATA;
		err = PSLVERR;
		@(posedge PCLK);
		PSEL <= 1'b0;
		PENABLE <= 1'b0;
	endtask

	task automatic apbWrite(input logic [31:0] addr, input logic [31:0] data, input logic expErr);
		logic [31:0] unused;
		logic err;
		apbAccess(1'b1, addr, data, unused, err);
		checkFlag(err, expErr, $sformatf("PSLVERR on write to %h", addr));
	endtask

	task automatic apbRead(input logic [31:0] addr, output logic [31:0] data, input logic expErr);
		logic err;
		apbAccess(1'b0, addr, '0, data, err);
		checkFlag(err, expErr, $sformatf("PSLVERR on read of %h", addr));
	endtask

	task automatic checkIrqs(input logic expTx, input logic expRx);
		@(negedge PCLK);
		checkFlag(intTx, expTx, "intTx");
		checkFlag(intRx, expRx, "intRx");
	endtask

	task automatic waitForStops(input int target, input int maxCycles);
		int cycles;
		cycles = 0;
		while (stopCount < target)
		begin
			@(posedge PCLK);
			cycles++;
			if (cycles > maxCycles)
				failNow($sformatf("no STOP on the bus within %0d cycles", maxCycles));
		end
		// Every transfer here opens with exactly one START
		if (startCount != stopCount)
			failNow($sformatf("%0d STARTs seen for %0d STOPs", startCount, stopCount));
	endtask

	function automatic logic [31:0] cfgWord(input logic en, input logic irq);
		cfgWord = '0;
		cfgWord[apbI2cRegPkg::cfgDivMsb:apbI2cRegPkg::cfgDivLsb] = divSel;
		cfgWord[apbI2cRegPkg::cfgEnableBit] = en;
		cfgWord[apbI2cRegPkg::cfgIrqEnableBit] = irq;
	endfunction

	function automatic logic [31:0] statusWord(input logic txE, input logic rxE,
		input logic nack, input logic tmo);
		statusWord = '0;
		statusWord[apbI2cRegPkg::statusTxEmptyBit] = txE;
		statusWord[apbI2cRegPkg::statusRxEmptyBit] = rxE;
		statusWord[apbI2cRegPkg::statusNackBit] = nack;
		statusWord[apbI2cRegPkg::statusTimeoutBit] = tmo;
	endfunction

	// TX words built through the union views
	function automatic logic [31:0] addrWord(input logic [6:0] addr, input logic rnw,
		input logic stop);
		i2cBusPkg::i2cTxWord w;
		w.addrView.stop = stop;
		w.addrView.start = 1'b1;
		w.addrView.addr = addr;
		w.addrView.readNotWrite = rnw;
		addrWord = '0;
		addrWord[i2cBusPkg::txWordWidth-1:0] = w;
	endfunction

	function automatic logic [31:0] dataWord(input logic [7:0] data, input logic stop);
		i2cBusPkg::i2cTxWord w;
		w.dataView.stop = stop;
		w.dataView.start = 1'b0;
		w.dataView.data = data;
		dataWord = '0;
		dataWord[i2cBusPkg::txWordWidth-1:0] = w;
	endfunction

	// Watchdog sized from the transfers chosen at run start
	initial
	begin
		wait (limitNs != 0);
		#(limitNs);
		$display("Watchdog expired, the run did not finish in time");
		$display("RESULT: FAIL");
		$fatal(1, "watchdog");
	end

	////////////////////
	// Test sequence
	////////////////////
	initial
	begin : mainSeq
		logic [31:0] rnd;
		logic [31:0] rd;
		logic [6:0] other;
		int target;
		PRESETn = 1'b0;
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = '0;
		PWDATA = '0;
		rnd = $urandom(32'h8364de9f);
		rnd = $urandom;
		slaveAddr = rnd[6:0];
		divSel = {6'd0, rnd[9:8]};
		nData = 1 + int'(rnd[12:10] % 3'd6);
		nRead = 1 + int'(rnd[15:13] % 3'd6);
		toLimit = 14'd20 + {7'd0, rnd[22:16]};
		busCycles = 36 * (int'(divSel) + 1);
		limitNs = longint'((nData + nRead + 13) * busCycles * 4 * 2 + 2 * int'(toLimit) * 4 + 4000);
		repeat (2) @(posedge PCLK);
		PRESETn <= 1'b1;

		// 1: register readback and unmapped addresses
		for (int i = 0; i < 8; i++)
		begin
			rnd = $urandom;
			apbWrite(apbI2cRegPkg::configAddr, rnd, 1'b0);
			apbRead(apbI2cRegPkg::configAddr, rd, 1'b0);
			checkRegWord(rd[apbI2cRegPkg::regWidth-1:0], rnd[apbI2cRegPkg::regWidth-1:0], "config");
			checkFlag(|rd[apbI2cRegPkg::apbDataWidth-1:apbI2cRegPkg::regWidth], 1'b0,
				"config bits above the register");
			rnd = $urandom;
			apbWrite(apbI2cRegPkg::timeoutAddr, rnd, 1'b0);
			apbRead(apbI2cRegPkg::timeoutAddr, rd, 1'b0);
			checkRegWord(rd[apbI2cRegPkg::regWidth-1:0], rnd[apbI2cRegPkg::regWidth-1:0], "timeout");
			checkFlag(|rd[apbI2cRegPkg::apbDataWidth-1:apbI2cRegPkg::regWidth], 1'b0,
				"timeout bits above the register");
			rnd = $urandom;
			apbWrite(32'd20 + {rnd[29:0], 2'b00}, rnd, 1'b1);
			apbRead(32'd20 + {rnd[29:0], 2'b01}, rd, 1'b1);
		end

		// 2: write transfer
		apbWrite(apbI2cRegPkg::timeoutAddr, '0, 1'b0);
		apbWrite(apbI2cRegPkg::configAddr, cfgWord(1'b0, 1'b1), 1'b0);
		expBus.push_back({slaveAddr, 1'b0});
		apbWrite(apbI2cRegPkg::txDataAddr, addrWord(slaveAddr, 1'b0, 1'b0), 1'b0);
		for (int i = 0; i < nData; i++)
		begin
			rnd = $urandom;
			expBus.push_back(rnd[7:0]);
			apbWrite(apbI2cRegPkg::txDataAddr, dataWord(rnd[7:0], i == nData - 1), 1'b0);
		end
		target = stopCount + 1;
		apbWrite(apbI2cRegPkg::configAddr, cfgWord(1'b1, 1'b1), 1'b0);
		waitForStops(target, (nData + 3) * busCycles * 2);
		if (busBytes.size() != expBus.size())
			failNow($sformatf("slave saw %0d bytes, expected %0d", busBytes.size(), expBus.size()));
		for (int i = 0; i < expBus.size(); i++)
			checkBusByte(busBytes[i], expBus[i], "write transfer byte");

		// 3: read transfer
		busBytes.delete();
		apbWrite(apbI2cRegPkg::configAddr, cfgWord(1'b0, 1'b1), 1'b0);
		for (int i = 0; i < nRead; i++)
		begin
			rnd = $urandom;
			slaveData.push_back(rnd[7:0]);
			expRx.push_back(rnd[7:0]);
		end
		apbWrite(apbI2cRegPkg::txDataAddr, addrWord(slaveAddr, 1'b1, 1'b0), 1'b0);
		for (int i = 0; i < nRead; i++)
			apbWrite(apbI2cRegPkg::txDataAddr, dataWord(8'h00, i == nRead - 1), 1'b0);
		target = stopCount + 1;
		apbWrite(apbI2cRegPkg::configAddr, cfgWord(1'b1, 1'b1), 1'b0);
		waitForStops(target, (nRead + 3) * busCycles * 2);
		checkBusByte(busBytes[0], {slaveAddr, 1'b1}, "read address byte");
		checkIrqs(1'b1, 1'b1);
		// RX holds data, so the gate alone must pull both interrupts low
		apbWrite(apbI2cRegPkg::configAddr, cfgWord(1'b1, 1'b0), 1'b0);
		checkIrqs(1'b0, 1'b0);
		apbWrite(apbI2cRegPkg::configAddr, cfgWord(1'b1, 1'b1), 1'b0);
		for (int i = 0; i < nRead; i++)
		begin
			apbRead(apbI2cRegPkg::rxDataAddr, rd, 1'b0);
			checkBusByte(rd[7:0], expRx[i], "RX byte");
		end
		checkIrqs(1'b1, 1'b0);
		apbRead(apbI2cRegPkg::rxDataAddr, rd, 1'b1);

		// 4: address NACK, cleared by a config write
		rnd = $urandom;
		other = slaveAddr ^ (rnd[6:0] | 7'h01);
		target = stopCount + 1;
		apbWrite(apbI2cRegPkg::txDataAddr, addrWord(other, 1'b0, 1'b1), 1'b0);
		waitForStops(target, 3 * busCycles * 2);
		apbRead(apbI2cRegPkg::statusAddr, rd, 1'b0);
		checkStatus(rd, statusWord(1'b1, 1'b1, 1'b1, 1'b0));
		apbWrite(apbI2cRegPkg::configAddr, cfgWord(1'b1, 1'b1), 1'b0);
		apbRead(apbI2cRegPkg::statusAddr, rd, 1'b0);
		checkStatus(rd, statusWord(1'b1, 1'b1, 1'b0, 1'b0));

		// 5: stalled transfer times out with a STOP
		apbWrite(apbI2cRegPkg::timeoutAddr, {18'd0, toLimit}, 1'b0);
		target = stopCount + 1;
		rnd = $urandom;
		apbWrite(apbI2cRegPkg::txDataAddr, addrWord(slaveAddr, 1'b0, 1'b0), 1'b0);
		apbWrite(apbI2cRegPkg::txDataAddr, dataWord(rnd[7:0], 1'b0), 1'b0);
		waitForStops(target, 4 * busCycles + 2 * int'(toLimit));
		apbRead(apbI2cRegPkg::statusAddr, rd, 1'b0);
		checkStatus(rd, statusWord(1'b1, 1'b1, 1'b0, 1'b1));

		// 6: overflow and interrupt gating with the engine off
		apbWrite(apbI2cRegPkg::configAddr, cfgWord(1'b0, 1'b0), 1'b0);
		checkIrqs(1'b0, 1'b0);
		apbWrite(apbI2cRegPkg::configAddr, cfgWord(1'b0, 1'b1), 1'b0);
		checkIrqs(1'b1, 1'b0);
		for (int i = 0; i <= txDepth; i++)
		begin
			rnd = $urandom;
			apbWrite(apbI2cRegPkg::txDataAddr, dataWord(rnd[7:0], 1'b0), i == txDepth);
		end
		checkIrqs(1'b0, 1'b0);
		apbRead(apbI2cRegPkg::statusAddr, rd, 1'b0);
		checkStatus(rd, statusWord(1'b0, 1'b1, 1'b0, 1'b0));

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== dv/apbI2c_chk.sv ====
////////////////////
// Port-level APB and I2C checks, bound into the bridge top
// FIFO levels come from the top-level wires
////////////////////
`timescale 1ns/100ps

module apbI2c_chk (
	input logic PCLK,
	input logic PRESETn,
	input logic PSEL,
	input logic PENABLE,
	input logic PREADY,
	input logic PSLVERR,
	input logic sclOe,
	input logic sdaOe,
	input logic intTx,
	input logic intRx,
	input logic txEmpty,
	input logic rxEmpty
);

	// Zero wait states
	readyRule: assert property (@(posedge PCLK) PREADY == (PSEL && PENABLE))
		else $error("PREADY differs from PSEL and PENABLE");
	errPhase: assert property (@(posedge PCLK) PSLVERR |-> (PSEL && PENABLE))
		else $error("PSLVERR outside the access phase");
	// Interrupts only with the matching FIFO level
	txIrq: assert property (@(posedge PCLK) intTx |-> txEmpty)
		else $error("intTx high with TX not empty");
	rxIrq: assert property (@(posedge PCLK) intRx |-> !rxEmpty)
		else $error("intRx high with RX empty");
	pinsReset: assert property (@(posedge PCLK) !PRESETn |=> (!sclOe && !sdaOe))
		else $error("Bus enables active after reset");

endmodule

bind apbI2c apbI2c_chk chk (.*);

// ==== hdl/apbI2c.sv ====
////////////////////
// APB to I2C bridge top, one master on an open-drain bus
// txDepth and rxDepth size the FIFOs, each at least 2
////////////////////
`timescale 1ns/100ps

module apbI2c #(
	parameter int txDepth = 8,
	parameter int rxDepth = 8
) (
	input  logic PCLK,
	input  logic PRESETn,
	input  logic PSEL,
	input  logic PENABLE,
	input  logic PWRITE,
	input  logic [apbI2cRegPkg::apbDataWidth-1:0] PADDR,
	input  logic [apbI2cRegPkg::apbDataWidth-1:0] PWDATA,
	output logic [apbI2cRegPkg::apbDataWidth-1:0] PRDATA,
	output logic PREADY,
	output logic PSLVERR,
	// I2C pins, low enables
	output logic sclOe,
	output logic sdaOe,
	input  logic sdaIn,
	// Level interrupts
	output logic intTx,
	output logic intRx
);

	// TX path
	logic txPush;
	logic [i2cBusPkg::txWordWidth-1:0] txPushData;
	logic txPop;
	logic [i2cBusPkg::txWordWidth-1:0] txHead;
	logic txEmpty;
	logic txFull;
	// RX path
	logic rxPush;
	logic [i2cBusPkg::rxWordWidth-1:0] rxPushData;
	logic rxPop;
	logic [i2cBusPkg::rxWordWidth-1:0] rxHead;
	logic rxEmpty;
	logic rxFull;
	// Configuration and engine status
	logic [apbI2cRegPkg::cfgDivMsb-apbI2cRegPkg::cfgDivLsb:0] sclDiv;
	logic busEnable;
	logic [apbI2cRegPkg::regWidth-1:0] timeoutLimit;
	logic errClear;
	logic nackErr;
	logic timeoutErr;

	// Port names match the local wires one to one
	apbRegs regs (.*);

	wordFifo #(
		.depth(txDepth),
		.width(i2cBusPkg::txWordWidth)
	) txFifo (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.push(txPush), .pushData(txPushData), .pop(txPop),
		.head(txHead), .empty(txEmpty), .full(txFull)
	);

	wordFifo #(
		.depth(rxDepth),
		.width(i2cBusPkg::rxWordWidth)
	) rxFifo (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.push(rxPush), .pushData(rxPushData), .pop(rxPop),
		.head(rxHead), .empty(rxEmpty), .full(rxFull)
	);

	i2cEngine engine (.*);

endmodule

// ==== hdl/apbI2cRegPkg.sv ====
////////////////////
// APB register map and config field layout
// Offsets are full 32-bit byte addresses, all others are unmapped
// Config and timeout keep only their low 14 bits
////////////////////
package apbI2cRegPkg;

	// Bus and register widths
	localparam int apbDataWidth = 32;
	localparam int regWidth = 14;

	// Register offsets
	localparam logic [apbDataWidth-1:0] txDataAddr = 32'd0;
	localparam logic [apbDataWidth-1:0] rxDataAddr = 32'd4;
	localparam logic [apbDataWidth-1:0] configAddr = 32'd8;
	localparam logic [apbDataWidth-1:0] timeoutAddr = 32'd12;
	localparam logic [apbDataWidth-1:0] statusAddr = 32'd16;

	// Config register fields
	localparam int cfgDivLsb = 0;
	localparam int cfgDivMsb = 7;
	localparam int cfgEnableBit = 8;
	localparam int cfgIrqEnableBit = 9;

	// Status word bits
	localparam int statusTxEmptyBit = 0;
	localparam int statusRxEmptyBit = 1;
	localparam int statusNackBit = 2;
	localparam int statusTimeoutBit = 3;

endpackage

// ==== hdl/apbRegs.sv ====
////////////////////
// APB slave without wait states, PREADY is PSEL and PENABLE
// Errors answer with PSLVERR and leave all state unchanged
////////////////////
`timescale 1ns/100ps

module apbRegs (
	input  logic PCLK,
	input  logic PRESETn,
	input  logic PSEL,
	input  logic PENABLE,
	input  logic PWRITE,
	input  logic [apbI2cRegPkg::apbDataWidth-1:0] PADDR,
	input  logic [apbI2cRegPkg::apbDataWidth-1:0] PWDATA,
	output logic [apbI2cRegPkg::apbDataWidth-1:0] PRDATA,
	output logic PREADY,
	output logic PSLVERR,
	// FIFO levels and engine errors
	input  logic txFull,
	input  logic txEmpty,
	input  logic rxEmpty,
	input  logic [i2cBusPkg::rxWordWidth-1:0] rxHead,
	input  logic nackErr,
	input  logic timeoutErr,
	// Strobes and configuration out
	output logic txPush,
	output logic [i2cBusPkg::txWordWidth-1:0] txPushData,
	output logic rxPop,
	output logic [apbI2cRegPkg::cfgDivMsb-apbI2cRegPkg::cfgDivLsb:0] sclDiv,
	output logic busEnable,
	output logic [apbI2cRegPkg::regWidth-1:0] timeoutLimit,
	output logic errClear,
	output logic intTx,
	output logic intRx
);

	logic [apbI2cRegPkg::regWidth-1:0] configReg;
	logic [apbI2cRegPkg::regWidth-1:0] timeoutReg;
	logic access;
	logic selTx;
	logic selRx;
	logic selCfg;
	logic selTimeout;
	logic selStatus;
	logic badAccess;
	logic irqEnable;

	////////////////////
	// Address decode
	////////////////////
	assign access = PSEL & PENABLE;
	assign PREADY = access;
	assign selTx = PADDR == apbI2cRegPkg::txDataAddr;
	assign selRx = PADDR == apbI2cRegPkg::rxDataAddr;
	assign selCfg = PADDR == apbI2cRegPkg::configAddr;
	assign selTimeout = PADDR == apbI2cRegPkg::timeoutAddr;
	assign selStatus = PADDR == apbI2cRegPkg::statusAddr;

	// TX overflow, RX underflow, read-only targets and holes in the map
	assign badAccess = (PWRITE & selTx & txFull) | (!PWRITE & selRx & rxEmpty)
		| (PWRITE & (selRx | selStatus))
		| !(selTx | selRx | selCfg | selTimeout | selStatus);
	assign PSLVERR = access & badAccess;

	// FIFO strobes fire on the edge that ends the access phase
	assign txPush = access & PWRITE & selTx & !badAccess;
	assign txPushData = PWDATA[i2cBusPkg::txWordWidth-1:0];
	assign rxPop = access & !PWRITE & selRx & !badAccess;
	// Any config write clears the sticky engine errors
	assign errClear = access & PWRITE & selCfg;

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			configReg <= '0;
			timeoutReg <= '0;
		end
		else if (access & PWRITE)
		begin
			if (selCfg)
				configReg <= PWDATA[apbI2cRegPkg::regWidth-1:0];
			if (selTimeout)
				timeoutReg <= PWDATA[apbI2cRegPkg::regWidth-1:0];
		end
	end

	// Read mux, zero for the TX offset and unmapped addresses
	always_comb
	begin
		PRDATA = '0;
		if (selRx)
			PRDATA[i2cBusPkg::rxWordWidth-1:0] = rxHead;
		else if (selStatus)
		begin
			PRDATA[apbI2cRegPkg::statusTxEmptyBit] = txEmpty;
			PRDATA[apbI2cRegPkg::statusRxEmptyBit] = rxEmpty;
			PRDATA[apbI2cRegPkg::statusNackBit] = nackErr;
			PRDATA[apbI2cRegPkg::statusTimeoutBit] = timeoutErr;
		end
		else if (selCfg)
			PRDATA[apbI2cRegPkg::regWidth-1:0] = configReg;
		else if (selTimeout)
			PRDATA[apbI2cRegPkg::regWidth-1:0] = timeoutReg;
	end

	////////////////////
	// Config fields and level interrupts
	////////////////////
	assign sclDiv = configReg[apbI2cRegPkg::cfgDivMsb:apbI2cRegPkg::cfgDivLsb];
	assign busEnable = configReg[apbI2cRegPkg::cfgEnableBit];
	assign irqEnable = configReg[apbI2cRegPkg::cfgIrqEnableBit];
	assign timeoutLimit = timeoutReg;
	assign intTx = irqEnable & txEmpty;
	assign intRx = irqEnable & !rxEmpty;

endmodule

// ==== hdl/i2cBusPkg.sv ====
////////////////////
// TX and RX word formats of the I2C engine, 7-bit addressing only
////////////////////
package i2cBusPkg;

	localparam int txWordWidth = 10;
	localparam int rxWordWidth = 8;

	// First word after a start flag
	typedef struct packed {
		logic stop;
		logic start;
		logic [6:0] addr;
		logic readNotWrite;
	} i2cAddrView;

	// Any later word of the same transfer
	typedef struct packed {
		logic stop;
		logic start;
		logic [7:0] data;
	} i2cDataView;

	// Same 10 bits, decoded by position in the transfer
	typedef union packed {
		i2cAddrView addrView;
		i2cDataView dataView;
	} i2cTxWord;

	// Engine FSM states
	typedef enum logic [2:0] {idle, startCond, shiftByte, ackBit, readByte, masterAck, stopCond}
		engineState;

endpackage

// ==== hdl/i2cEngine.sv ====
////////////////////
// Single I2C master, no arbitration, SCL never sampled
// sclOe and sdaOe are open-drain low enables, registered
// Bit period is 4 quarters of sclDiv+1 PCLK cycles each
////////////////////
`timescale 1ns/100ps

module i2cEngine (
	input  logic PCLK,
	input  logic PRESETn,
	input  logic [apbI2cRegPkg::cfgDivMsb-apbI2cRegPkg::cfgDivLsb:0] sclDiv,
	input  logic busEnable,
	input  logic [apbI2cRegPkg::regWidth-1:0] timeoutLimit,
	input  logic errClear,
	input  i2cBusPkg::i2cTxWord txHead,
	input  logic txEmpty,
	input  logic rxFull,
	output logic txPop,
	output logic rxPush,
	output logic [i2cBusPkg::rxWordWidth-1:0] rxPushData,
	output logic nackErr,
	output logic timeoutErr,
	output logic sclOe,
	output logic sdaOe,
	input  logic sdaIn
);

	i2cBusPkg::engineState state;
	logic [apbI2cRegPkg::cfgDivMsb-apbI2cRegPkg::cfgDivLsb:0] divCnt;
	logic [1:0] phase;
	logic [2:0] bitCnt;
	logic [7:0] shiftReg;
	logic [apbI2cRegPkg::regWidth-1:0] waitCnt;
	// Bus owned between START and STOP
	logic busy;
	logic readMode;
	logic stopFlag;
	logic sampled;
	logic tick;
	logic bitEnd;
	logic sclLow;
	logic sdaLow;

	assign tick = divCnt == sclDiv;
	assign bitEnd = tick & (phase == 2'd3);

	////////////////////
	// Pin levels per state and quarter
	////////////////////
	always_comb
	begin
		// Data bits keep SCL low in the first and last quarter
		sclLow = (phase == 2'd0) | (phase == 2'd3);
		sdaLow = 1'b0;
		case (state)
			i2cBusPkg::idle:
				sclLow = busy;
			i2cBusPkg::startCond:
			begin
				// SCL low in quarter 0 only for a repeated START
				sclLow = ((phase == 2'd0) & busy) | (phase == 2'd3);
				sdaLow = phase[1];
			end
			i2cBusPkg::shiftByte:
				sdaLow = !shiftReg[7];
			i2cBusPkg::masterAck:
				sdaLow = !stopFlag;
			i2cBusPkg::stopCond:
			begin
				sclLow = phase == 2'd0;
				sdaLow = !phase[1];
			end
			default:
				sdaLow = 1'b0;
		endcase
	end

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state <= i2cBusPkg::idle;
			divCnt <= '0;
			phase <= '0;
			bitCnt <= '0;
			waitCnt <= '0;
			busy <= 1'b0;
			readMode <= 1'b0;
			stopFlag <= 1'b0;
			txPop <= 1'b0;
			rxPush <= 1'b0;
			nackErr <= 1'b0;
			timeoutErr <= 1'b0;
			sclOe <= 1'b0;
			sdaOe <= 1'b0;
		end
		else
		begin
			sclOe <= sclLow;
			sdaOe <= sdaLow;
			txPop <= 1'b0;
			rxPush <= 1'b0;
			if (errClear)
			begin
				nackErr <= 1'b0;
				timeoutErr <= 1'b0;
			end
			// Quarter timebase, parked while idle so each bit starts aligned
			if (state == i2cBusPkg::idle || tick)
				divCnt <= '0;
			else
				divCnt <= divCnt + 1'b1;
			if (tick && state != i2cBusPkg::idle)
				phase <= phase + 1'b1;
			// Sample mid-high, SCL has been released for a full quarter
			if (tick && phase == 2'd2)
				sampled <= sdaIn;
			case (state)
				i2cBusPkg::idle:
				begin
					// Stalled mid-transfer with nothing queued
					if (busy && txEmpty && timeoutLimit != '0)
					begin
						if (waitCnt == timeoutLimit)
						begin
							timeoutErr <= 1'b1;
							waitCnt <= '0;
							state <= i2cBusPkg::stopCond;
						end
						else
							waitCnt <= waitCnt + 1'b1;
					end
					else
						waitCnt <= '0;
					// txPop still high means the head word is the one just taken
					if (busEnable && !txEmpty && !txPop)
					begin
						stopFlag <= txHead.dataView.stop;
						if (txHead.addrView.start)
						begin
							txPop <= 1'b1;
							readMode <= txHead.addrView.readNotWrite;
							shiftReg <= {txHead.addrView.addr, txHead.addrView.readNotWrite};
							state <= i2cBusPkg::startCond;
						end
						// Data word outside a transfer is dropped
						else if (!busy)
							txPop <= 1'b1;
						else if (!readMode)
						begin
							txPop <= 1'b1;
							shiftReg <= txHead.dataView.data;
							state <= i2cBusPkg::shiftByte;
						end
						// Reads wait here with SCL low until RX has room
						else if (!rxFull)
						begin
							txPop <= 1'b1;
							state <= i2cBusPkg::readByte;
						end
					end
				end
				i2cBusPkg::startCond:
					if (bitEnd)
					begin
						busy <= 1'b1;
						state <= i2cBusPkg::shiftByte;
					end
				i2cBusPkg::shiftByte, i2cBusPkg::readByte:
					if (bitEnd)
					begin
						// MSB first both ways, write side ignores the fill bit
						shiftReg <= {shiftReg[6:0], sampled};
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == 3'd7 && state == i2cBusPkg::readByte)
						begin
							rxPush <= 1'b1;
							rxPushData <= {shiftReg[6:0], sampled};
							state <= i2cBusPkg::masterAck;
						end
						else if (bitCnt == 3'd7)
							state <= i2cBusPkg::ackBit;
					end
				i2cBusPkg::ackBit:
					if (bitEnd)
					begin
						// Slave NACK ends the transfer
						if (sampled)
						begin
							nackErr <= 1'b1;
							state <= i2cBusPkg::stopCond;
						end
						else if (stopFlag)
							state <= i2cBusPkg::stopCond;
						else
							state <= i2cBusPkg::idle;
					end
				i2cBusPkg::masterAck:
					if (bitEnd)
						state <= stopFlag ? i2cBusPkg::stopCond : i2cBusPkg::idle;
				i2cBusPkg::stopCond:
					if (bitEnd)
					begin
						busy <= 1'b0;
						state <= i2cBusPkg::idle;
					end
				default:
					state <= i2cBusPkg::idle;
			endcase
		end
	end

endmodule

// ==== hdl/wordFifo.sv ====
////////////////////
// First-word-fall-through FIFO, depth of at least 2
// Push when full and pop when empty are dropped
////////////////////
`timescale 1ns/100ps

module wordFifo #(
	parameter int depth = 8,
	parameter int width = 8
) (
	input  logic PCLK,
	input  logic PRESETn,
	input  logic push,
	input  logic [width-1:0] pushData,
	input  logic pop,
	output logic [width-1:0] head,
	output logic empty,
	output logic full
);

	localparam int ptrWidth = $clog2(depth);

	logic [width-1:0] mem [depth];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	// One extra bit so a full FIFO fits
	logic [ptrWidth:0] count;
	logic doPush;
	logic doPop;

	assign doPush = push & !full;
	assign doPop = pop & !empty;
	assign empty = count == '0;
	assign full = count == (ptrWidth+1)'(depth);
	// Head word is valid while not empty
	assign head = mem[rdPtr];

	always_ff @(posedge PCLK)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap at depth, so depth need not be a power of two
			if (doPush)
				wrPtr <= (wrPtr == ptrWidth'(depth-1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == ptrWidth'(depth-1)) ? '0 : rdPtr + 1'b1;
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module apbI2cTb -f apbI2c.f -o simv \
	&& ./obj_dir/simv 2>&1 | tee sim.log \
	|| { echo "Simulation build or run failed"; exit 1; }

! grep -q "RESULT: FAIL" sim.log && grep -q "RESULT: PASS" sim.log \
	|| { echo "Simulation reported failure"; exit 1; }
